//--- common/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int word_width     = 32;
    localparam int dword_width    = 64;  // the HI:LO pair and a full product.
    localparam int reg_addr_width = 5;
    localparam int shamt_width    = 5;

    // operation codes follow the decoder's existing numbering.
    typedef enum logic [7:0] {
        OP_NOP   = 8'b0000_0000,
        OP_OR    = 8'b0010_0101,
        OP_AND   = 8'b0010_0100,
        OP_NOR   = 8'b0010_0111,
        OP_XOR   = 8'b0010_0110,
        OP_SLL   = 8'b0111_1100,
        OP_SRL   = 8'b0000_0010,
        OP_SRA   = 8'b0000_0011,
        OP_SLT   = 8'b0010_1010,
        OP_SLTU  = 8'b0010_1011,
        OP_ADD   = 8'b0010_0000,
        OP_ADDU  = 8'b0010_0001,
        OP_ADDI  = 8'b0101_0101,
        OP_ADDIU = 8'b0101_0110,
        OP_SUB   = 8'b0010_0010,
        OP_SUBU  = 8'b0010_0011,
        OP_CLZ   = 8'b1011_0000,
        OP_CLO   = 8'b1011_0001,
        OP_MUL   = 8'b1010_1001,
        OP_MULT  = 8'b0001_1000,
        OP_MULTU = 8'b0001_1001,
        OP_MADD  = 8'b1010_0110,
        OP_MADDU = 8'b1010_1000,
        OP_MSUB  = 8'b1010_1010,
        OP_MSUBU = 8'b1010_1011,
        OP_MFHI  = 8'b0001_0000,
        OP_MFLO  = 8'b0001_0010,
        OP_MTHI  = 8'b0001_0001,
        OP_MTLO  = 8'b0001_0011
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100,
        SEL_MUL   = 3'b101
    } alusel_e;

    typedef enum logic {
        MAC_IDLE  = 1'b0,
        MAC_ACCUM = 1'b1
    } mac_phase_e;

endpackage

`default_nettype wire

//--- alu/alu_logic_shift.sv
`timescale 1ns/1ps
`default_nettype none

module alu_logic_shift (
    input  wire ex_pkg::aluop_e            aluop,
    input  wire [ex_pkg::word_width-1:0]   reg1,
    input  wire [ex_pkg::word_width-1:0]   reg2,
    output logic [ex_pkg::word_width-1:0]  logic_shift_result
);

    logic [ex_pkg::shamt_width-1:0] shamt;

    assign shamt = reg1[ex_pkg::shamt_width-1:0];  // only the low bits of reg1 count.

    always_comb begin
        case (aluop)
            ex_pkg::OP_OR: begin
                logic_shift_result = reg1 | reg2;
            end
            ex_pkg::OP_AND: begin
                logic_shift_result = reg1 & reg2;
            end
            ex_pkg::OP_NOR: begin
                logic_shift_result = ~(reg1 | reg2);
            end
            ex_pkg::OP_XOR: begin
                logic_shift_result = reg1 ^ reg2;
            end
            ex_pkg::OP_SLL: begin
                logic_shift_result = reg2 << shamt;
            end
            ex_pkg::OP_SRL: begin
                logic_shift_result = reg2 >> shamt;
            end
            ex_pkg::OP_SRA: begin
                // the signed cast makes the shift fill with the sign bit.
                logic_shift_result = $signed(reg2) >>> shamt;
            end
            default: begin
                logic_shift_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- alu/alu_arith.sv
`timescale 1ns/1ps
`default_nettype none

module alu_arith (
    input  wire ex_pkg::aluop_e            aluop,
    input  wire [ex_pkg::word_width-1:0]   reg1,
    input  wire [ex_pkg::word_width-1:0]   reg2,
    output logic [ex_pkg::word_width-1:0]  arith_result,
    output logic                           overflow
);

    logic                          subtract;
    logic [ex_pkg::word_width-1:0] operand_b;
    logic [ex_pkg::word_width-1:0] sum;
    logic                          operand_b_sign;
    logic                          sum_overflow;
    logic                          less_than;

    function automatic logic [5:0] leading_zeros(input logic [ex_pkg::word_width-1:0] value);
        logic [5:0] count;
        logic       seen_one;
        count = 6'd0;
        seen_one = 1'b0;
        for (int i = ex_pkg::word_width - 1; i >= 0; i--) begin
            if (value[i]) begin
                seen_one = 1'b1;
            end else if (!seen_one) begin
                count = count + 6'd1;
            end
        end
        return count;
    endfunction

    assign subtract = (aluop == ex_pkg::OP_SUB) || (aluop == ex_pkg::OP_SUBU) ||
                      (aluop == ex_pkg::OP_SLT);
    assign operand_b = subtract ? (~reg2 + 1'b1) : reg2;
    assign sum = reg1 + operand_b;

    // sign of the value actually added, so that subtracting the most negative word is caught.
    assign operand_b_sign = subtract ? ~reg2[ex_pkg::word_width-1] : reg2[ex_pkg::word_width-1];
    assign sum_overflow = (reg1[ex_pkg::word_width-1] == operand_b_sign) &&
                          (sum[ex_pkg::word_width-1] != reg1[ex_pkg::word_width-1]);

    // a signed difference that overflowed has its sign bit flipped.
    assign less_than = (aluop == ex_pkg::OP_SLT) ? (sum[ex_pkg::word_width-1] ^ sum_overflow)
                                                 : (reg1 < reg2);

    assign overflow = sum_overflow && ((aluop == ex_pkg::OP_ADD) ||
                                       (aluop == ex_pkg::OP_ADDI) ||
                                       (aluop == ex_pkg::OP_SUB));

    always_comb begin
        case (aluop)
            ex_pkg::OP_SLT, ex_pkg::OP_SLTU: begin
                arith_result = {{(ex_pkg::word_width-1){1'b0}}, less_than};
            end
            ex_pkg::OP_ADD, ex_pkg::OP_ADDU, ex_pkg::OP_ADDI, ex_pkg::OP_ADDIU,
            ex_pkg::OP_SUB, ex_pkg::OP_SUBU: begin
                arith_result = sum;
            end
            ex_pkg::OP_CLZ: begin
                arith_result = {{(ex_pkg::word_width-6){1'b0}}, leading_zeros(reg1)};
            end
            ex_pkg::OP_CLO: begin
                arith_result = {{(ex_pkg::word_width-6){1'b0}}, leading_zeros(~reg1)};
            end
            default: begin
                arith_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- mul/mul_acc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_acc_unit (
    input  wire                             clock,
    input  wire                             reset,
    input  wire                             issue_valid,
    input  wire ex_pkg::aluop_e             aluop,
    input  wire [ex_pkg::word_width-1:0]    reg1,
    input  wire [ex_pkg::word_width-1:0]    reg2,
    input  wire [ex_pkg::word_width-1:0]    hi,
    input  wire [ex_pkg::word_width-1:0]    lo,
    output logic                            stall,
    output logic                            issue_accept,
    output logic [ex_pkg::word_width-1:0]   product_low,
    output logic                            hilo_write,
    output logic [ex_pkg::dword_width-1:0]  hilo_value
);

    ex_pkg::mac_phase_e                     phase;
    logic                                   signed_op;
    logic                                   accum_op;
    logic                                   negate_op;
    logic                                   mult_hilo_op;
    logic signed [ex_pkg::word_width:0]     mult_a;
    logic signed [ex_pkg::word_width:0]     mult_b;
    logic signed [ex_pkg::dword_width+1:0]  product_full;
    logic [ex_pkg::dword_width-1:0]         product;
    logic [ex_pkg::dword_width-1:0]         partial;
    logic [ex_pkg::dword_width-1:0]         accum_sum;

    assign signed_op = aluop inside {ex_pkg::OP_MUL, ex_pkg::OP_MULT,
                                     ex_pkg::OP_MADD, ex_pkg::OP_MSUB};
    assign accum_op = aluop inside {ex_pkg::OP_MADD, ex_pkg::OP_MADDU,
                                    ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU};
    assign negate_op = (aluop == ex_pkg::OP_MSUB) || (aluop == ex_pkg::OP_MSUBU);
    assign mult_hilo_op = (aluop == ex_pkg::OP_MULT) || (aluop == ex_pkg::OP_MULTU);

    // one extra top bit lets a single signed multiplier cover both kinds.
    assign mult_a = {signed_op & reg1[ex_pkg::word_width-1], reg1};
    assign mult_b = {signed_op & reg2[ex_pkg::word_width-1], reg2};
    assign product_full = mult_a * mult_b;
    assign product = product_full[ex_pkg::dword_width-1:0];
    assign product_low = product[ex_pkg::word_width-1:0];

    assign stall = issue_valid && accum_op && (phase == ex_pkg::MAC_IDLE);
    assign issue_accept = issue_valid && !stall;

    assign accum_sum = partial + {hi, lo};

    assign hilo_write = issue_accept &&
                        (mult_hilo_op || (accum_op && (phase == ex_pkg::MAC_ACCUM)));
    assign hilo_value = accum_op ? accum_sum : product;

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= ex_pkg::MAC_IDLE;
        end else if (issue_valid && accum_op) begin
            if (phase == ex_pkg::MAC_IDLE) begin
                phase <= ex_pkg::MAC_ACCUM;  // first cycle, product captured.
            end else begin
                phase <= ex_pkg::MAC_IDLE;   // second cycle, HI:LO updated.
            end
        end
    end

    always_ff @(posedge clock) begin
        if (stall) begin
            partial <= negate_op ? (~product + 1'b1) : product;
        end
    end

endmodule

`default_nettype wire

//--- design/hilo_regs.sv
`timescale 1ns/1ps
`default_nettype none

module hilo_regs (
    input  wire                             clock,
    input  wire                             reset,
    input  wire                             issue_accept,
    input  wire ex_pkg::aluop_e             aluop,
    input  wire [ex_pkg::word_width-1:0]    reg1,
    input  wire                             hilo_write,
    input  wire [ex_pkg::dword_width-1:0]   hilo_value,
    output logic [ex_pkg::word_width-1:0]   hi,
    output logic [ex_pkg::word_width-1:0]   lo
);

    // nothing changes unless the operation is actually taken this edge.
    always_ff @(posedge clock) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (issue_accept) begin
            if (hilo_write) begin
                hi <= hilo_value[ex_pkg::dword_width-1:ex_pkg::word_width];
                lo <= hilo_value[ex_pkg::word_width-1:0];
            end else if (aluop == ex_pkg::OP_MTHI) begin
                hi <= reg1;  // lo keeps its value.
            end else if (aluop == ex_pkg::OP_MTLO) begin
                lo <= reg1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/result_select.sv
`timescale 1ns/1ps
`default_nettype none

module result_select (
    input  wire                                clock,
    input  wire                                reset,
    input  wire                                issue_accept,
    input  wire ex_pkg::aluop_e                aluop,
    input  wire ex_pkg::alusel_e               alusel,
    input  wire [ex_pkg::reg_addr_width-1:0]   dest_address,
    input  wire                                dest_write,
    input  wire [ex_pkg::word_width-1:0]       logic_shift_result,
    input  wire [ex_pkg::word_width-1:0]       arith_result,
    input  wire                                overflow,
    input  wire [ex_pkg::word_width-1:0]       product_low,
    input  wire [ex_pkg::word_width-1:0]       hi,
    input  wire [ex_pkg::word_width-1:0]       lo,
    output logic                               result_valid,
    output logic [ex_pkg::reg_addr_width-1:0]  write_reg_address,
    output logic                               write_reg_enable,
    output logic [ex_pkg::word_width-1:0]      write_reg_data
);

    logic [ex_pkg::word_width-1:0] select_data;

    always_comb begin
        case (alusel)
            ex_pkg::SEL_LOGIC, ex_pkg::SEL_SHIFT: begin
                select_data = logic_shift_result;
            end
            ex_pkg::SEL_ARITH: begin
                select_data = arith_result;
            end
            ex_pkg::SEL_MUL: begin
                select_data = product_low;
            end
            ex_pkg::SEL_MOVE: begin
                if (aluop == ex_pkg::OP_MFHI) begin
                    select_data = hi;
                end else if (aluop == ex_pkg::OP_MFLO) begin
                    select_data = lo;
                end else begin
                    select_data = '0;  // mthi and mtlo write no register.
                end
            end
            default: begin
                select_data = '0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result_valid <= 1'b0;
            write_reg_enable <= 1'b0;
        end else begin
            result_valid <= issue_accept;
            write_reg_enable <= issue_accept && dest_write && !overflow;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_accept) begin
            write_reg_address <= dest_address;
            write_reg_data <= select_data;
        end
    end

endmodule

`default_nettype wire

//--- design/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire                                clock,
    input  wire                                reset,
    input  wire                                issue_valid,
    input  wire ex_pkg::aluop_e                aluop,
    input  wire ex_pkg::alusel_e               alusel,
    input  wire [ex_pkg::word_width-1:0]       reg1,
    input  wire [ex_pkg::word_width-1:0]       reg2,
    input  wire [ex_pkg::reg_addr_width-1:0]   dest_address,
    input  wire                                dest_write,
    output logic                               stall,
    output logic                               result_valid,
    output logic [ex_pkg::reg_addr_width-1:0]  write_reg_address,
    output logic                               write_reg_enable,
    output logic [ex_pkg::word_width-1:0]      write_reg_data
);

    logic                           issue_accept;
    logic                           hilo_write;
    logic [ex_pkg::dword_width-1:0] hilo_value;
    logic [ex_pkg::word_width-1:0]  hi;
    logic [ex_pkg::word_width-1:0]  lo;
    logic [ex_pkg::word_width-1:0]  logic_shift_result;
    logic [ex_pkg::word_width-1:0]  arith_result;
    logic                           overflow;
    logic [ex_pkg::word_width-1:0]  product_low;

    alu_logic_shift u_alu_logic_shift (
        .aluop              (aluop),
        .reg1               (reg1),
        .reg2               (reg2),
        .logic_shift_result (logic_shift_result)
    );

    alu_arith u_alu_arith (
        .aluop        (aluop),
        .reg1         (reg1),
        .reg2         (reg2),
        .arith_result (arith_result),
        .overflow     (overflow)
    );

    // the multiplier also owns the stall and the accept condition.
    mul_acc_unit u_mul_acc_unit (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .aluop        (aluop),
        .reg1         (reg1),
        .reg2         (reg2),
        .hi           (hi),
        .lo           (lo),
        .stall        (stall),
        .issue_accept (issue_accept),
        .product_low  (product_low),
        .hilo_write   (hilo_write),
        .hilo_value   (hilo_value)
    );

    hilo_regs u_hilo_regs (
        .clock        (clock),
        .reset        (reset),
        .issue_accept (issue_accept),
        .aluop        (aluop),
        .reg1         (reg1),
        .hilo_write   (hilo_write),
        .hilo_value   (hilo_value),
        .hi           (hi),
        .lo           (lo)
    );

    result_select u_result_select (
        .clock              (clock),
        .reset              (reset),
        .issue_accept       (issue_accept),
        .aluop              (aluop),
        .alusel             (alusel),
        .dest_address       (dest_address),
        .dest_write         (dest_write),
        .logic_shift_result (logic_shift_result),
        .arith_result       (arith_result),
        .overflow           (overflow),
        .product_low        (product_low),
        .hi                 (hi),
        .lo                 (lo),
        .result_valid       (result_valid),
        .write_reg_address  (write_reg_address),
        .write_reg_enable   (write_reg_enable),
        .write_reg_data     (write_reg_data)
    );

endmodule

`default_nettype wire

//--- dv/ex_stage_tb_table.svh
`ifndef EX_STAGE_TB_TABLE_SVH
`define EX_STAGE_TB_TABLE_SVH

// columns: aluop, alusel, reg1, reg2, dest_address, dest_write,
// expected write_reg_data, expected write_reg_enable.
task automatic build_table();
    add_row(ex_pkg::OP_MFHI, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd1, 1'b1, 'h0, 1'b1);
    add_row(ex_pkg::OP_OR, ex_pkg::SEL_LOGIC, 'hf0f01234, 'h0f0f4321, 5'd2, 1'b1, 'hffff5335, 1'b1);
    add_row(ex_pkg::OP_AND, ex_pkg::SEL_LOGIC, 'hff00ff00, 'h0ff00ff0, 5'd3, 1'b1, 'h0f000f00, 1'b1);
    add_row(ex_pkg::OP_NOR, ex_pkg::SEL_LOGIC, 'hf0f00000, 'hf0f, 5'd4, 1'b1, 'h0f0ff0f0, 1'b1);
    add_row(ex_pkg::OP_XOR, ex_pkg::SEL_LOGIC, 'haaaa5555, 'hffff0000, 5'd5, 1'b1, 'h55555555, 1'b1);
    add_row(ex_pkg::OP_SLL, ex_pkg::SEL_SHIFT, 'h4, 'hff, 5'd6, 1'b1, 'hff0, 1'b1);
    add_row(ex_pkg::OP_SRL, ex_pkg::SEL_SHIFT, 'h8, 'h80000000, 5'd7, 1'b1, 'h00800000, 1'b1);
    add_row(ex_pkg::OP_SRA, ex_pkg::SEL_SHIFT, 'h4, 'h80000000, 5'd8, 1'b1, 'hf8000000, 1'b1);
    add_row(ex_pkg::OP_SRA, ex_pkg::SEL_SHIFT, 'h24, 'hf00, 5'd9, 1'b1, 'hf0, 1'b1);  // bit 5 ignored
    add_row(ex_pkg::OP_ADD, ex_pkg::SEL_ARITH, 'h5, 'h7, 5'd10, 1'b1, 'hc, 1'b1);
    add_row(ex_pkg::OP_SUB, ex_pkg::SEL_ARITH, 'h3, 'h5, 5'd11, 1'b1, 'hfffffffe, 1'b1);
    add_row(ex_pkg::OP_SLT, ex_pkg::SEL_ARITH, 'hffffffff, 'h1, 5'd12, 1'b1, 'h1, 1'b1);
    add_row(ex_pkg::OP_SLTU, ex_pkg::SEL_ARITH, 'hffffffff, 'h1, 5'd13, 1'b1, 'h0, 1'b1);
    add_row(ex_pkg::OP_SLT, ex_pkg::SEL_ARITH, 'h80000000, 'h7fffffff, 5'd14, 1'b1, 'h1, 1'b1);
    add_row(ex_pkg::OP_CLZ, ex_pkg::SEL_ARITH, 'h0, 'h0, 5'd15, 1'b1, 'd32, 1'b1);
    add_row(ex_pkg::OP_CLZ, ex_pkg::SEL_ARITH, 'h00010000, 'h0, 5'd16, 1'b1, 'd15, 1'b1);
    add_row(ex_pkg::OP_CLO, ex_pkg::SEL_ARITH, 'hffffffff, 'h0, 5'd17, 1'b1, 'd32, 1'b1);
    // signed overflow drops the register write, the unsigned forms keep it.
    add_row(ex_pkg::OP_ADDI, ex_pkg::SEL_ARITH, 'h7fffffff, 'h1, 5'd18, 1'b1, 'h80000000, 1'b0);
    add_row(ex_pkg::OP_ADD, ex_pkg::SEL_ARITH, 'h7fffffff, 'h1, 5'd19, 1'b1, 'h80000000, 1'b0);
    add_row(ex_pkg::OP_ADDU, ex_pkg::SEL_ARITH, 'h7fffffff, 'h1, 5'd20, 1'b1, 'h80000000, 1'b1);
    add_row(ex_pkg::OP_SUB, ex_pkg::SEL_ARITH, 'h80000000, 'h1, 5'd21, 1'b1, 'h7fffffff, 1'b0);
    add_row(ex_pkg::OP_SUBU, ex_pkg::SEL_ARITH, 'h80000000, 'h1, 5'd22, 1'b1, 'h7fffffff, 1'b1);
    add_row(ex_pkg::OP_MUL, ex_pkg::SEL_MUL, 'hfffffffe, 'h3, 5'd23, 1'b1, 'hfffffffa, 1'b1);
    add_row(ex_pkg::OP_MULT, ex_pkg::SEL_NOP, 'hffffffff, 'h2, 5'd0, 1'b0, 'h0, 1'b0);
    add_row(ex_pkg::OP_MFHI, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd24, 1'b1, 'hffffffff, 1'b1);
    add_row(ex_pkg::OP_MFLO, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd25, 1'b1, 'hfffffffe, 1'b1);
    add_row(ex_pkg::OP_MULTU, ex_pkg::SEL_NOP, 'hffffffff, 'h2, 5'd0, 1'b0, 'h0, 1'b0);
    add_row(ex_pkg::OP_MFHI, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd26, 1'b1, 'h1, 1'b1);
    add_row(ex_pkg::OP_MFLO, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd27, 1'b1, 'hfffffffe, 1'b1);
    add_row(ex_pkg::OP_MTHI, ex_pkg::SEL_NOP, 'h12345678, 'h0, 5'd0, 1'b0, 'h0, 1'b0);
    add_row(ex_pkg::OP_MFHI, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd28, 1'b1, 'h12345678, 1'b1);
    add_row(ex_pkg::OP_MFLO, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd29, 1'b1, 'hfffffffe, 1'b1);
    add_row(ex_pkg::OP_MTLO, ex_pkg::SEL_NOP, 'h10, 'h0, 5'd0, 1'b0, 'h0, 1'b0);
    add_row(ex_pkg::OP_MFHI, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd30, 1'b1, 'h12345678, 1'b1);
    add_row(ex_pkg::OP_MFLO, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd31, 1'b1, 'h10, 1'b1);
    add_row(ex_pkg::OP_MADD, ex_pkg::SEL_NOP, 'h3, 'h4, 5'd0, 1'b0, 'h0, 1'b0);
    add_row(ex_pkg::OP_MFHI, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd1, 1'b1, 'h12345678, 1'b1);
    add_row(ex_pkg::OP_MFLO, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd2, 1'b1, 'h1c, 1'b1);
    add_row(ex_pkg::OP_MSUB, ex_pkg::SEL_NOP, 'h2, 'h10, 5'd0, 1'b0, 'h0, 1'b0);  // borrows into hi
    add_row(ex_pkg::OP_MFHI, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd3, 1'b1, 'h12345677, 1'b1);
    add_row(ex_pkg::OP_MFLO, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd4, 1'b1, 'hfffffffc, 1'b1);
    add_row(ex_pkg::OP_MADDU, ex_pkg::SEL_NOP, 'hffffffff, 'h2, 5'd0, 1'b0, 'h0, 1'b0);
    add_row(ex_pkg::OP_MFHI, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd5, 1'b1, 'h12345679, 1'b1);
    add_row(ex_pkg::OP_MFLO, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd6, 1'b1, 'hfffffffa, 1'b1);
    burst_start = op_q.size();  // the remaining rows issue back to back.
    add_row(ex_pkg::OP_ADD, ex_pkg::SEL_ARITH, 'h1, 'h2, 5'd7, 1'b1, 'h3, 1'b1);
    add_row(ex_pkg::OP_XOR, ex_pkg::SEL_LOGIC, 'hffffffff, 'hffff, 5'd8, 1'b1, 'hffff0000, 1'b1);
    add_row(ex_pkg::OP_MTLO, ex_pkg::SEL_NOP, 'habcd0000, 'h0, 5'd0, 1'b0, 'h0, 1'b0);
    add_row(ex_pkg::OP_MFLO, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd9, 1'b1, 'habcd0000, 1'b1);
    add_row(ex_pkg::OP_MADD, ex_pkg::SEL_NOP, 'h1, 'h1, 5'd0, 1'b0, 'h0, 1'b0);
    add_row(ex_pkg::OP_MFLO, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd10, 1'b1, 'habcd0001, 1'b1);
    add_row(ex_pkg::OP_MFHI, ex_pkg::SEL_MOVE, 'h0, 'h0, 5'd11, 1'b1, 'h12345679, 1'b1);
endtask

`endif

//--- dv/ex_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;

    localparam int clock_period = 4;
    localparam int wait_limit   = 20;

    logic                               clock;
    logic                               reset;
    logic                               issue_valid;
    ex_pkg::aluop_e                     aluop;
    ex_pkg::alusel_e                    alusel;
    logic [ex_pkg::word_width-1:0]      reg1;
    logic [ex_pkg::word_width-1:0]      reg2;
    logic [ex_pkg::reg_addr_width-1:0]  dest_address;
    logic                               dest_write;
    wire                                stall;
    wire                                result_valid;
    wire [ex_pkg::reg_addr_width-1:0]   write_reg_address;
    wire                                write_reg_enable;
    wire [ex_pkg::word_width-1:0]       write_reg_data;

    ex_pkg::aluop_e                     op_q[$];
    ex_pkg::alusel_e                    sel_q[$];
    logic [ex_pkg::word_width-1:0]      reg1_q[$];
    logic [ex_pkg::word_width-1:0]      reg2_q[$];
    logic [ex_pkg::reg_addr_width-1:0]  addr_q[$];
    logic                               write_q[$];
    logic [ex_pkg::word_width-1:0]      data_q[$];
    logic                               enable_q[$];
    int                                 burst_start;
    int                                 error_count;
    int                                 rows_passed;
    int                                 rows_failed;
    logic [15:0]                        lfsr_state;
    bit                                 timed_out;

    ex_stage DUT (
        .clock             (clock),
        .reset             (reset),
        .issue_valid       (issue_valid),
        .aluop             (aluop),
        .alusel            (alusel),
        .reg1              (reg1),
        .reg2              (reg2),
        .dest_address      (dest_address),
        .dest_write        (dest_write),
        .stall             (stall),
        .result_valid      (result_valid),
        .write_reg_address (write_reg_address),
        .write_reg_enable  (write_reg_enable),
        .write_reg_data    (write_reg_data)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // galois form of x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    task automatic draw_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] time %0d ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic add_row(input ex_pkg::aluop_e op, input ex_pkg::alusel_e sel,
                           input logic [ex_pkg::word_width-1:0] r1,
                           input logic [ex_pkg::word_width-1:0] r2,
                           input logic [ex_pkg::reg_addr_width-1:0] addr, input logic write,
                           input logic [ex_pkg::word_width-1:0] data, input logic enable);
        op_q.push_back(op);
        sel_q.push_back(sel);
        reg1_q.push_back(r1);
        reg2_q.push_back(r2);
        addr_q.push_back(addr);
        write_q.push_back(write);
        data_q.push_back(data);
        enable_q.push_back(enable);
    endtask

    `include "ex_stage_tb_table.svh"

    // stall is sampled mid-cycle; returns just after the accepting edge.
    task automatic wait_accept(output int stall_cycles, output bit ok);
        stall_cycles = 0;
        ok = 1'b1;
        @(negedge clock);
        while (stall) begin
            stall_cycles++;
            if (stall_cycles > wait_limit) begin
                $display("timeout: stall stayed high for more than %0d cycles", wait_limit);
                ok = 1'b0;
                return;
            end
            @(negedge clock);
        end
        @(posedge clock);
        #1;
    endtask

    task automatic wait_result(output int cycles, output bit ok);
        cycles = 0;
        ok = 1'b1;
        while (!result_valid) begin
            cycles++;
            if (cycles > wait_limit) begin
                $display("timeout: no valid result within %0d cycles", wait_limit);
                ok = 1'b0;
                return;
            end
            @(posedge clock);
            #1;
        end
    endtask

    initial begin
        int idle;
        int stall_cycles;
        int expected_stall;
        int result_wait;
        int row_errors;
        bit ok;
        issue_valid = 1'b0;
        aluop = ex_pkg::OP_NOP;
        alusel = ex_pkg::SEL_NOP;
        reg1 = '0;
        reg2 = '0;
        dest_address = '0;
        dest_write = 1'b0;
        reset = 1'b1;
        error_count = 0;
        rows_passed = 0;
        rows_failed = 0;
        timed_out = 1'b0;
        burst_start = 0;
        lfsr_state = 16'd99;
        build_table();
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        check_value("result_valid", 32'(result_valid), 32'h0);
        check_value("write_reg_enable", 32'(write_reg_enable), 32'h0);
        check_value("stall", 32'(stall), 32'h0);
        for (int i = 0; i < op_q.size(); i++) begin
            idle = 0;
            if (i < burst_start) begin
                draw_bits(2, idle);
            end
            repeat (idle) begin
                @(posedge clock);
                #1;
            end
            row_errors = error_count;
            issue_valid = 1'b1;
            aluop = op_q[i];
            alusel = sel_q[i];
            reg1 = reg1_q[i];
            reg2 = reg2_q[i];
            dest_address = addr_q[i];
            dest_write = write_q[i];
            wait_accept(stall_cycles, ok);
            if (!ok) begin
                timed_out = 1'b1;
                break;
            end
            issue_valid = 1'b0;
            wait_result(result_wait, ok);
            if (!ok) begin
                timed_out = 1'b1;
                break;
            end
            expected_stall = (op_q[i] inside {ex_pkg::OP_MADD, ex_pkg::OP_MADDU,
                                              ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU}) ? 1 : 0;
            check_value("stall cycles", 32'(stall_cycles), 32'(expected_stall));
            // the result is due right after the accepting edge, with no extra cycle.
            check_value("result delay cycles", 32'(result_wait), 32'h0);
            check_value("write_reg_address", 32'(write_reg_address), 32'(addr_q[i]));
            check_value("write_reg_enable", 32'(write_reg_enable), 32'(enable_q[i]));
            check_value("write_reg_data", write_reg_data, data_q[i]);
            if (error_count == row_errors) begin
                rows_passed++;
                $display("row %0d %s passed", i, op_q[i].name());
            end else begin
                rows_failed++;
                $display("row %0d %s failed", i, op_q[i].name());
            end
        end
        repeat (2) @(posedge clock);
        $display("rows passed %0d, rows failed %0d, errors %0d", rows_passed, rows_failed,
                 error_count);
        if (!timed_out && error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ex_stage.f
+incdir+dv
common/ex_pkg.sv
alu/alu_logic_shift.sv
alu/alu_arith.sv
mul/mul_acc_unit.sv
design/hilo_regs.sv
design/result_select.sv
design/ex_stage.sv
dv/ex_stage_tb.sv

//--- Makefile
# Verilator build and run for the execute stage.

VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= ex_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_TEXT ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) $(VFLAGS)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST) $(VFLAGS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
